// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    // 3R group, inst[31:15]
    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_SLT     = 17'h00024;
    localparam logic [16:0] OP_SLTU    = 17'h00025;
    localparam logic [16:0] OP_AND     = 17'h00029;
    localparam logic [16:0] OP_OR      = 17'h0002a;
    localparam logic [16:0] OP_XOR     = 17'h0002b;

    // 2RI12 group, inst[31:22]
    localparam logic [9:0]  OP_SLTI    = 10'h008;
    localparam logic [9:0]  OP_SLTUI   = 10'h009;
    localparam logic [9:0]  OP_ADDI_W  = 10'h00a;
    localparam logic [9:0]  OP_ANDI    = 10'h00d;
    localparam logic [9:0]  OP_ORI     = 10'h00e;
    localparam logic [9:0]  OP_XORI    = 10'h00f;

    // 1RI20, inst[31:25]
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;

    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd7; // passes operand b

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r3;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] imm;
            logic [4:0]  rd;
        } ri20;
    } inst_word_u;

endpackage

// ==== logic/inst_decoder.sv ====
module inst_decoder (
    input  cpu_pkg::inst_word_u                inst_i,
    output logic [cpu_pkg::REG_ADDR_W-1:0]     rj_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0]     rk_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0]     rd_o,
    output logic [cpu_pkg::XLEN-1:0]           imm_o,
    output logic                               use_imm_o,
    output logic [cpu_pkg::ALU_OP_W-1:0]       alu_op_o,
    output logic                               reg_write_o
);

    logic        known;
    logic [11:0] imm12;

    // register fields sit at the same bits in every layout
    assign rd_o  = inst_i.r3.rd;
    assign rj_o  = inst_i.r3.rj;
    assign rk_o  = inst_i.r3.rk;
    assign imm12 = inst_i.ri12.imm;

    always_comb
    begin
        known     = 1'b0;
        use_imm_o = 1'b0;
        alu_op_o  = cpu_pkg::ALU_ADD;
        imm_o     = '0;

        case (inst_i.r3.opcode)
            cpu_pkg::OP_ADD_W: begin known = 1'b1; alu_op_o = cpu_pkg::ALU_ADD;  end
            cpu_pkg::OP_SUB_W: begin known = 1'b1; alu_op_o = cpu_pkg::ALU_SUB;  end
            cpu_pkg::OP_SLT:   begin known = 1'b1; alu_op_o = cpu_pkg::ALU_SLT;  end
            cpu_pkg::OP_SLTU:  begin known = 1'b1; alu_op_o = cpu_pkg::ALU_SLTU; end
            cpu_pkg::OP_AND:   begin known = 1'b1; alu_op_o = cpu_pkg::ALU_AND;  end
            cpu_pkg::OP_OR:    begin known = 1'b1; alu_op_o = cpu_pkg::ALU_OR;   end
            cpu_pkg::OP_XOR:   begin known = 1'b1; alu_op_o = cpu_pkg::ALU_XOR;  end
            default: ;
        endcase

        // si12 forms
        case (inst_i.ri12.opcode)
            cpu_pkg::OP_ADDI_W: alu_op_o = cpu_pkg::ALU_ADD;
            cpu_pkg::OP_SLTI:   alu_op_o = cpu_pkg::ALU_SLT;
            cpu_pkg::OP_SLTUI:  alu_op_o = cpu_pkg::ALU_SLTU;
            default: ;
        endcase
        if (inst_i.ri12.opcode == cpu_pkg::OP_ADDI_W ||
            inst_i.ri12.opcode == cpu_pkg::OP_SLTI   ||
            inst_i.ri12.opcode == cpu_pkg::OP_SLTUI)
        begin
            known     = 1'b1;
            use_imm_o = 1'b1;
            imm_o     = {{(cpu_pkg::XLEN-12){imm12[11]}}, imm12};
        end

        // ui12 forms, zero extended
        case (inst_i.ri12.opcode)
            cpu_pkg::OP_ANDI: begin known = 1'b1; alu_op_o = cpu_pkg::ALU_AND; end
            cpu_pkg::OP_ORI:  begin known = 1'b1; alu_op_o = cpu_pkg::ALU_OR;  end
            cpu_pkg::OP_XORI: begin known = 1'b1; alu_op_o = cpu_pkg::ALU_XOR; end
            default: ;
        endcase
        if (inst_i.ri12.opcode == cpu_pkg::OP_ANDI ||
            inst_i.ri12.opcode == cpu_pkg::OP_ORI  ||
            inst_i.ri12.opcode == cpu_pkg::OP_XORI)
        begin
            use_imm_o = 1'b1;
            imm_o     = {{(cpu_pkg::XLEN-12){1'b0}}, imm12};
        end

        if (inst_i.ri20.opcode == cpu_pkg::OP_LU12I_W)
        begin
            known     = 1'b1;
            use_imm_o = 1'b1;
            alu_op_o  = cpu_pkg::ALU_LUI;
            imm_o     = {inst_i.ri20.imm, 12'b0}; // si20 into bits 31:12
        end
    end

    // unknown words and rd of r0 never write
    assign reg_write_o = known && (rd_o != '0);

endmodule

// ==== logic/reg_file.sv ====
module reg_file (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [cpu_pkg::XLEN-1:0]       rdata1_o,
    output logic [cpu_pkg::XLEN-1:0]       rdata2_o,
    input  logic                           we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [cpu_pkg::XLEN-1:0]       wdata_i
);

    logic [cpu_pkg::XLEN-1:0] regs [1:31]; // r0 has no storage

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we_i && waddr_i != '0)
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write is seen by the reader
    assign rdata1_o = (raddr1_i == '0)                   ? '0      :
                      (we_i && waddr_i == raddr1_i)      ? wdata_i :
                                                           regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)                   ? '0      :
                      (we_i && waddr_i == raddr2_i)      ? wdata_i :
                                                           regs[raddr2_i];

endmodule

// ==== logic/forward_unit.sv ====
module forward_unit (
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_rj_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_rk_i,
    input  logic [cpu_pkg::XLEN-1:0]       ex_rj_data_i,
    input  logic [cpu_pkg::XLEN-1:0]       ex_rk_data_i,
    input  logic                           wb_we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [cpu_pkg::XLEN-1:0]       wb_data_i,
    output logic [cpu_pkg::XLEN-1:0]       opnd_a_o,
    output logic [cpu_pkg::XLEN-1:0]       opnd_b_o
);

    // one source: r0, then writeback hit, then the copy from decode
    function automatic logic [cpu_pkg::XLEN-1:0] pick (
        input logic [cpu_pkg::REG_ADDR_W-1:0] addr,
        input logic [cpu_pkg::XLEN-1:0]       stored
    );
        if (addr == '0)
            return '0;
        else if (wb_we_i && wb_rd_i == addr)
            return wb_data_i;
        else
            return stored;
    endfunction

    assign opnd_a_o = pick(ex_rj_i, ex_rj_data_i);
    assign opnd_b_o = pick(ex_rk_i, ex_rk_data_i);

endmodule

// ==== logic/alu.sv ====
module alu (
    input  logic [cpu_pkg::ALU_OP_W-1:0] alu_op_i,
    input  logic [cpu_pkg::XLEN-1:0]     a_i,
    input  logic [cpu_pkg::XLEN-1:0]     b_i,
    output logic [cpu_pkg::XLEN-1:0]     result_o
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb
    begin
        case (alu_op_i)
            cpu_pkg::ALU_ADD:  result_o = a_i + b_i;
            cpu_pkg::ALU_SUB:  result_o = a_i - b_i;
            cpu_pkg::ALU_SLT:  result_o = {{(cpu_pkg::XLEN-1){1'b0}}, lt_signed};
            cpu_pkg::ALU_SLTU: result_o = {{(cpu_pkg::XLEN-1){1'b0}}, lt_unsigned};
            cpu_pkg::ALU_AND:  result_o = a_i & b_i;
            cpu_pkg::ALU_OR:   result_o = a_i | b_i;
            cpu_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            cpu_pkg::ALU_LUI:  result_o = b_i; // immediate already shifted
            default:           result_o = '0;
        endcase
    end

endmodule

// ==== logic/pipe_core.sv ====
module pipe_core (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cpu_pkg::XLEN-1:0]       inst_i,
    input  logic                           inst_valid_i,
    output logic                           wb_valid_o,
    output logic [cpu_pkg::XLEN-1:0]       wb_pc_o,
    output logic                           wb_rf_we_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_rf_wnum_o,
    output logic [cpu_pkg::XLEN-1:0]       wb_rf_wdata_o
);

    logic [cpu_pkg::XLEN-1:0]       pc;

    // fetch/decode
    logic                           fd_valid;
    cpu_pkg::inst_word_u            fd_inst;
    logic [cpu_pkg::XLEN-1:0]       fd_pc;

    logic [cpu_pkg::REG_ADDR_W-1:0] dec_rj, dec_rk, dec_rd;
    logic [cpu_pkg::XLEN-1:0]       dec_imm;
    logic                           dec_use_imm;
    logic [cpu_pkg::ALU_OP_W-1:0]   dec_alu_op;
    logic                           dec_we;
    logic [cpu_pkg::XLEN-1:0]       rf_rdata1, rf_rdata2;

    // decode/execute
    logic                           de_valid;
    logic                           de_we;
    logic [cpu_pkg::XLEN-1:0]       de_pc;
    logic [cpu_pkg::REG_ADDR_W-1:0] de_rj, de_rk, de_rd;
    logic [cpu_pkg::XLEN-1:0]       de_imm;
    logic                           de_use_imm;
    logic [cpu_pkg::ALU_OP_W-1:0]   de_alu_op;
    logic [cpu_pkg::XLEN-1:0]       de_rj_data, de_rk_data;

    logic [cpu_pkg::XLEN-1:0]       opnd_a, opnd_b, alu_b, alu_result;

    // execute/writeback
    logic                           ew_valid;
    logic                           ew_we;
    logic [cpu_pkg::XLEN-1:0]       ew_pc;
    logic [cpu_pkg::REG_ADDR_W-1:0] ew_rd;
    logic [cpu_pkg::XLEN-1:0]       ew_result;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            pc       <= cpu_pkg::RESET_PC;
            fd_valid <= 1'b0;
            de_valid <= 1'b0;
            de_we    <= 1'b0;
            ew_valid <= 1'b0;
            ew_we    <= 1'b0;
        end
        else
        begin
            if (inst_valid_i)
                pc <= pc + 32'd4;
            fd_valid <= inst_valid_i;
            de_valid <= fd_valid;
            de_we    <= fd_valid && dec_we; // bubbles never write
            ew_valid <= de_valid;
            ew_we    <= de_we;
        end
    end

    // payload only, qualified by the valid bits above
    always_ff @(posedge clk)
    begin
        fd_inst    <= inst_i;
        fd_pc      <= pc;
        de_pc      <= fd_pc;
        de_rj      <= dec_rj;
        de_rk      <= dec_rk;
        de_rd      <= dec_rd;
        de_imm     <= dec_imm;
        de_use_imm <= dec_use_imm;
        de_alu_op  <= dec_alu_op;
        de_rj_data <= rf_rdata1;
        de_rk_data <= rf_rdata2;
        ew_pc      <= de_pc;
        ew_rd      <= de_rd;
        ew_result  <= alu_result;
    end

    inst_decoder u_decoder (
        .inst_i      (fd_inst),
        .rj_o        (dec_rj),
        .rk_o        (dec_rk),
        .rd_o        (dec_rd),
        .imm_o       (dec_imm),
        .use_imm_o   (dec_use_imm),
        .alu_op_o    (dec_alu_op),
        .reg_write_o (dec_we)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .raddr1_i (dec_rj),
        .raddr2_i (dec_rk),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .we_i     (ew_we),
        .waddr_i  (ew_rd),
        .wdata_i  (ew_result)
    );

    forward_unit u_forward (
        .ex_rj_i      (de_rj),
        .ex_rk_i      (de_rk),
        .ex_rj_data_i (de_rj_data),
        .ex_rk_data_i (de_rk_data),
        .wb_we_i      (ew_we),
        .wb_rd_i      (ew_rd),
        .wb_data_i    (ew_result),
        .opnd_a_o     (opnd_a),
        .opnd_b_o     (opnd_b)
    );

    assign alu_b = de_use_imm ? de_imm : opnd_b;

    alu u_alu (
        .alu_op_i (de_alu_op),
        .a_i      (opnd_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    // trace port
    assign wb_valid_o    = ew_valid;
    assign wb_pc_o       = ew_pc;
    assign wb_rf_we_o    = ew_we;
    assign wb_rf_wnum_o  = ew_rd;
    assign wb_rf_wdata_o = ew_result;

endmodule

// ==== tb/wb_checker.sv ====
module wb_checker (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cpu_pkg::XLEN-1:0]       inst_i,
    input  logic                           inst_valid_i,
    input  logic                           wb_valid_i,
    input  logic [cpu_pkg::XLEN-1:0]       wb_pc_i,
    input  logic                           wb_rf_we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_rf_wnum_i,
    input  logic [cpu_pkg::XLEN-1:0]       wb_rf_wdata_i,
    output int                             retired_o
);

    logic [31:0] mregs [0:31];   // model register file
    int          last_wr [0:31]; // acceptance cycle of last writer
    logic [31:0] model_pc;
    int          cycle;
    logic        in_reset = 1'b0;
    int          checks [1:6];
    int          errors [1:6];

    // expected retirements, oldest first
    logic [31:0] q_pc [$];
    logic [31:0] q_data [$];
    int          q_due [$];
    int          q_test [$];
    logic [5:0]  q_dst [$]; // {we, rd}

    function automatic string test_name(input int t);
        case (t)
            1:       return "reset state and pc sequence";
            2:       return "register-register results";
            3:       return "immediate operations";
            4:       return "forwarding";
            5:       return "r0 and unknown words";
            default: return "latency and order";
        endcase
    endfunction

    task automatic record(input int t, input logic ok, input string msg);
        checks[t]++;
        if (!ok)
        begin
            errors[t]++;
            $display("mismatch at time %0t: %s", $time, msg);
        end
    endtask

    task automatic drop_front();
        void'(q_pc.pop_front());
        void'(q_data.pop_front());
        void'(q_due.pop_front());
        void'(q_test.pop_front());
        void'(q_dst.pop_front());
        retired_o++;
    endtask

    // in-order reference: result from the model registers at acceptance
    task automatic accept(input logic [31:0] w);
        logic [31:0] a, b, si12, ui12, value;
        logic [4:0]  rd, rj, rk;
        logic        use_rj, use_rk, we, fwd;
        int          grp, test;
        rd = w[4:0];
        rj = w[9:5];
        rk = w[14:10];
        a = mregs[rj];
        b = mregs[rk];
        si12 = {{20{w[21]}}, w[21:10]};
        ui12 = {20'b0, w[21:10]};
        value = '0;
        grp = 2;
        use_rj = 1'b1;
        case (w[31:15])
            cpu_pkg::OP_ADD_W: value = a + b;
            cpu_pkg::OP_SUB_W: value = a - b;
            cpu_pkg::OP_SLT:   value = {31'b0, $signed(a) < $signed(b)};
            cpu_pkg::OP_SLTU:  value = {31'b0, a < b};
            cpu_pkg::OP_AND:   value = a & b;
            cpu_pkg::OP_OR:    value = a | b;
            cpu_pkg::OP_XOR:   value = a ^ b;
            default:           grp = 3;
        endcase
        if (grp == 3)
        begin
            case (w[31:22])
                cpu_pkg::OP_ADDI_W: value = a + si12;
                cpu_pkg::OP_SLTI:   value = {31'b0, $signed(a) < $signed(si12)};
                cpu_pkg::OP_SLTUI:  value = {31'b0, a < si12};
                cpu_pkg::OP_ANDI:   value = a & ui12;
                cpu_pkg::OP_ORI:    value = a | ui12;
                cpu_pkg::OP_XORI:   value = a ^ ui12;
                default:            grp = (w[31:25] == cpu_pkg::OP_LU12I_W) ? 3 : 5;
            endcase
        end
        if (w[31:25] == cpu_pkg::OP_LU12I_W)
        begin
            value = {w[24:5], 12'b0};
            use_rj = 1'b0;
        end
        use_rk = (grp == 2);
        we = (grp != 5) && (rd != 0);
        // a producer accepted one or two cycles back needs a bypass
        fwd = (use_rj && rj != 0 && cycle - last_wr[rj] <= 2) ||
              (use_rk && rk != 0 && cycle - last_wr[rk] <= 2);
        if (fwd)
            test = 4;
        else if ((use_rj && rj == 0) || (use_rk && rk == 0))
            test = 5;
        else
            test = grp;
        q_pc.push_back(model_pc);
        q_data.push_back(value);
        q_due.push_back(cycle + 3);
        q_test.push_back(test);
        q_dst.push_back({we, rd});
        if (we)
        begin
            mregs[rd] = value;
            last_wr[rd] = cycle;
        end
        model_pc = model_pc + 32'd4;
    endtask

    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (in_reset)
                record(1, wb_valid_i === 1'b0 && wb_rf_we_i === 1'b0,
                       "trace port active during reset");
            in_reset = 1'b1;
            model_pc = cpu_pkg::RESET_PC;
            cycle = 0;
            for (int i = 0; i < 32; i++)
            begin
                mregs[i] = '0;
                last_wr[i] = -100;
            end
        end
        else
        begin
            in_reset = 1'b0;
            cycle++;
            while (q_due.size() > 0 && q_due[0] < cycle)
            begin
                checks[6]++;
                errors[6]++;
                $display("instruction at pc %h did not retire on time", q_pc[0]);
                drop_front();
            end
            if (wb_valid_i === 1'b1)
            begin
                if (q_due.size() == 0)
                begin
                    checks[1]++;
                    errors[1]++;
                    $display("unexpected retirement of pc %h with no instruction due", wb_pc_i);
                end
                else
                begin
                    record(6, q_due[0] == cycle,
                           $sformatf("pc %h retired in cycle %0d, expected cycle %0d",
                                     q_pc[0], cycle, q_due[0]));
                    record(1, wb_pc_i === q_pc[0],
                           $sformatf("pc %h, expected %h", wb_pc_i, q_pc[0]));
                    record(q_dst[0][5] ? q_test[0] : 5, wb_rf_we_i === q_dst[0][5],
                           $sformatf("pc %h write enable %b, expected %b",
                                     q_pc[0], wb_rf_we_i, q_dst[0][5]));
                    if (q_dst[0][5])
                        record(q_test[0],
                               {wb_rf_wnum_i, wb_rf_wdata_i} === {q_dst[0][4:0], q_data[0]},
                               $sformatf("pc %h wrote r%0d = %h, expected r%0d = %h",
                                         q_pc[0], wb_rf_wnum_i, wb_rf_wdata_i,
                                         q_dst[0][4:0], q_data[0]));
                    drop_front();
                end
            end
            if (inst_valid_i === 1'b1)
                accept(inst_i);
        end
    end

    task automatic report_results(output int total_checks, output int total_errors);
        total_checks = 0;
        total_errors = 0;
        for (int t = 1; t <= 6; t++)
        begin
            $display("test %0d, %s: %0d checks, %0d errors",
                     t, test_name(t), checks[t], errors[t]);
            total_checks += checks[t];
            total_errors += errors[t];
        end
    endtask

endmodule

// ==== tb/core_assertions.sv ====
module core_assertions (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           inst_valid_i,
    input  logic                           wb_valid_i,
    input  logic                           wb_we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_wnum_i
);

    int fail_count = 0;

    we_needs_valid: assert property (@(posedge clk) disable iff (!reset)
        wb_we_i |-> wb_valid_i)
        else begin fail_count++; $error("write enable high without a retiring instruction"); end

    we_needs_rd: assert property (@(posedge clk) disable iff (!reset)
        wb_we_i |-> (wb_wnum_i != '0))
        else begin fail_count++; $error("write enable high for register r0"); end

    // strobe seen at edge k shows up on the trace port sampled at edge k+3
    valid_follows_strobe: assert property (@(posedge clk) disable iff (!reset)
        wb_valid_i == $past(inst_valid_i, 3))
        else begin fail_count++; $error("trace valid does not follow the accepted strobe"); end

endmodule

bind pipe_core core_assertions u_core_assertions (
    .clk          (clk),
    .reset        (reset),
    .inst_valid_i (inst_valid_i),
    .wb_valid_i   (wb_valid_o),
    .wb_we_i      (wb_rf_we_o),
    .wb_wnum_i    (wb_rf_wnum_o)
);

// ==== tb/tb_top.sv ====
module tb_top;

    logic                           clk;
    logic                           reset;
    logic [cpu_pkg::XLEN-1:0]       inst_i;
    logic                           inst_valid_i;
    logic                           wb_valid;
    logic [cpu_pkg::XLEN-1:0]       wb_pc;
    logic                           wb_rf_we;
    logic [cpu_pkg::REG_ADDR_W-1:0] wb_rf_wnum;
    logic [cpu_pkg::XLEN-1:0]       wb_rf_wdata;
    int                             retired;
    logic [31:0]                    lfsr;

    int   accepted;
    int   steps;
    int   total_checks;
    int   total_errors;
    int   assert_errors;
    logic timed_out;

    always #20 clk = ~clk;

    pipe_core uut (
        .clk           (clk),
        .reset         (reset),
        .inst_i        (inst_i),
        .inst_valid_i  (inst_valid_i),
        .wb_valid_o    (wb_valid),
        .wb_pc_o       (wb_pc),
        .wb_rf_we_o    (wb_rf_we),
        .wb_rf_wnum_o  (wb_rf_wnum),
        .wb_rf_wdata_o (wb_rf_wdata)
    );

    wb_checker chk (
        .clk           (clk),
        .reset         (reset),
        .inst_i        (inst_i),
        .inst_valid_i  (inst_valid_i),
        .wb_valid_i    (wb_valid),
        .wb_pc_i       (wb_pc),
        .wb_rf_we_i    (wb_rf_we),
        .wb_rf_wnum_i  (wb_rf_wnum),
        .wb_rf_wdata_i (wb_rf_wdata),
        .retired_o     (retired)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic build_inst(output logic [31:0] w);
        cpu_pkg::inst_word_u u;
        logic [31:0] kind, op, rd, rj, rk, imm;
        u = '0;
        take_bits(4, kind);
        take_bits(3, rd); // r0..r7 keeps dependencies dense
        take_bits(3, rj);
        take_bits(3, rk);
        if (kind == 0)
        begin
            take_bits(26, imm);
            w = {6'h3f, imm[25:0]}; // top bits match no opcode
        end
        else
        begin
            take_bits(4, op);
            op = op % 14;
            case (op)
                0:       u.r3.opcode = cpu_pkg::OP_ADD_W;
                1:       u.r3.opcode = cpu_pkg::OP_SUB_W;
                2:       u.r3.opcode = cpu_pkg::OP_SLT;
                3:       u.r3.opcode = cpu_pkg::OP_SLTU;
                4:       u.r3.opcode = cpu_pkg::OP_AND;
                5:       u.r3.opcode = cpu_pkg::OP_OR;
                6:       u.r3.opcode = cpu_pkg::OP_XOR;
                7:       u.ri12.opcode = cpu_pkg::OP_ADDI_W;
                8:       u.ri12.opcode = cpu_pkg::OP_SLTI;
                9:       u.ri12.opcode = cpu_pkg::OP_SLTUI;
                10:      u.ri12.opcode = cpu_pkg::OP_ANDI;
                11:      u.ri12.opcode = cpu_pkg::OP_ORI;
                12:      u.ri12.opcode = cpu_pkg::OP_XORI;
                default: u.ri20.opcode = cpu_pkg::OP_LU12I_W;
            endcase
            if (op < 7)
            begin
                u.r3.rk = rk[4:0];
                u.r3.rj = rj[4:0];
            end
            else if (op < 13)
            begin
                take_bits(12, imm);
                u.ri12.imm = imm[11:0];
                u.ri12.rj  = rj[4:0];
            end
            else
            begin
                take_bits(20, imm);
                u.ri20.imm = imm[19:0];
            end
            u.r3.rd = rd[4:0];
            w = u;
        end
    endtask

    initial
    begin
        logic [31:0] v;
        logic [31:0] w;
        clk = 1'b0;
        reset = 1'b0;
        inst_i = '0;
        inst_valid_i = 1'b0;
        lfsr = 32'h4fc8_cb4c;
        accepted = 0;
        steps = 0;
        timed_out = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        while (accepted < 400 && steps < 4000)
        begin
            take_bits(4, v);
            build_inst(w);
            inst_valid_i <= (v >= 3); // roughly one bubble in five
            inst_i <= w;
            if (v >= 3)
                accepted++;
            steps++;
            @(posedge clk);
        end
        inst_valid_i <= 1'b0;
        if (accepted < 400)
        begin
            timed_out = 1'b1;
            $display("stimulus loop ran out of steps before 400 instructions");
        end
        steps = 0;
        while (retired < accepted && steps < 50)
        begin
            @(negedge clk);
            steps++;
        end
        if (retired < accepted)
        begin
            timed_out = 1'b1;
            $display("timed out waiting for %0d instructions to retire", accepted - retired);
        end
        chk.report_results(total_checks, total_errors);
        assert_errors = uut.u_core_assertions.fail_count;
        $display("total: %0d checks, %0d errors, %0d assertion failures",
                 total_checks, total_errors, assert_errors);
        if (!timed_out && total_errors == 0 && assert_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== project.f ====
logic/cpu_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/forward_unit.sv
logic/alu.sv
logic/pipe_core.sv
tb/wb_checker.sv
tb/core_assertions.sv
tb/tb_top.sv
